// File: all.f
verilog/rvv_backend_pkg.sv
verilog/rvv_backend_dispatch_structure_hazard.sv
verilog/rvv_backend_dispatch_scoreboard.sv
verilog/rvv_backend_dispatch_ctrl.sv
verilog/rvv_backend_dispatch.sv
test/tb_clock_gen.sv
test/tb_rvv_backend_dispatch.sv

// File: test/tb_clock_gen.sv
// Clock and reset source for the dispatch testbench.
// 100-unit clock period, reset held high for the first 10 rising edges.

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: test/tb_rvv_backend_dispatch.sv
// Testbench for the vector dispatch stage. A uop queue feeds the DUT,
// a reference model tracks pending registers and issue slots, and
// concurrent assertions compare the DUT against the model every cycle.

module tb_rvv_backend_dispatch;

    localparam int timeout_cycles = 200;

    logic                              clk;
    logic                              reset;
    rvv_backend_pkg::strct_uop_t [1:0] uop_in = '0;
    logic                              alu_ready = 1'b0;
    logic                              mac_ready = 1'b0;
    logic                              wb_valid = 1'b0;
    rvv_backend_pkg::reg_index_t       wb_index = '0;
    logic [1:0]                        uop_accept;
    rvv_backend_pkg::reg_index_t [3:0] rd_index;
    rvv_backend_pkg::strct_uop_t [1:0] alu_issue;
    rvv_backend_pkg::strct_uop_t [1:0] mac_issue;

    rvv_backend_pkg::strct_uop_t       uop_q[$];
    rvv_backend_pkg::vreg_mask_t       model_pending;
    rvv_backend_pkg::vreg_mask_t       src0;
    rvv_backend_pkg::vreg_mask_t       src1;
    rvv_backend_pkg::reg_index_t [3:0] exp_rd;
    logic [5:0]                        t0;
    logic [5:0]                        t1;
    logic [1:0]                        unit_up;
    logic                              vr_hit;
    logic                              mac_pair;
    logic [1:0]                        exp_accept;
    // slots 0 and 1 are ALU and slots 2 and 3 are MAC
    rvv_backend_pkg::strct_uop_t [3:0] issue_next;
    rvv_backend_pkg::strct_uop_t [3:0] exp_issue;
    rvv_backend_pkg::strct_uop_t [3:0] dut_issue;
    logic [31:0]                       rng_state = 32'd33394;
    logic [7:0]                        next_tag = 8'd1;
    int                                errors = 0;
    int                                timeouts = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rvv_backend_dispatch i_rvv_backend_dispatch (
        .clk        (clk),
        .reset      (reset),
        .uop_in     (uop_in),
        .alu_ready  (alu_ready),
        .mac_ready  (mac_ready),
        .wb_valid   (wb_valid),
        .wb_index   (wb_index),
        .uop_accept (uop_accept),
        .rd_index   (rd_index),
        .alu_issue  (alu_issue),
        .mac_issue  (mac_issue)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // set of registers a uop reads
    function automatic rvv_backend_pkg::vreg_mask_t read_set(
        input rvv_backend_pkg::strct_uop_t u
    );
        logic [2:0] f;
        case (u.uop_class)
            rvv_backend_pkg::VVV: f = 3'b111;
            rvv_backend_pkg::VVX: f = 3'b110;
            rvv_backend_pkg::VXX: f = 3'b100;
            rvv_backend_pkg::XVV: f = 3'b011;
            rvv_backend_pkg::XVX: f = 3'b010;
            rvv_backend_pkg::XXV: f = 3'b001;
            default: f = 3'b000;
        endcase
        return ({31'b0, f[2]} << u.vd_index) | ({31'b0, f[1]} << u.vs2_index) |
               ({31'b0, f[0]} << u.vs1_index);
    endfunction

    // operand on rd0 / rd2
    function automatic rvv_backend_pkg::reg_index_t lead_port(
        input rvv_backend_pkg::strct_uop_t u
    );
        case (u.uop_class)
            rvv_backend_pkg::VXX: return u.vd_index;
            rvv_backend_pkg::XXV: return u.vs1_index;
            rvv_backend_pkg::XXX: return '0;
            default: return u.vs2_index;
        endcase
    endfunction

    // operand on rd1 / rd3 with a hit flag on top
    function automatic logic [5:0] tail_port(input rvv_backend_pkg::strct_uop_t u);
        case (u.uop_class)
            rvv_backend_pkg::VVV,
            rvv_backend_pkg::XVV: return {1'b1, u.vs1_index};
            rvv_backend_pkg::VVX: return {1'b1, u.vd_index};
            default: return 6'd0;
        endcase
    endfunction

    function automatic rvv_backend_pkg::reg_index_t lowest_set(
        input rvv_backend_pkg::vreg_mask_t m
    );
        rvv_backend_pkg::reg_index_t idx;
        idx = '0;
        for (int i = rvv_backend_pkg::num_vreg - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = rvv_backend_pkg::reg_index_t'(i);
            end
        end
        return idx;
    endfunction

    // expected read ports and dispatch decision
    always_comb begin
        t0 = tail_port(uop_in[0]);
        t1 = tail_port(uop_in[1]);
        exp_rd[0] = lead_port(uop_in[0]);
        exp_rd[2] = lead_port(uop_in[1]);
        exp_rd[1] = t0[5] ? t0[4:0] :
                    (uop_in[1].uop_class == rvv_backend_pkg::VVV ? uop_in[1].vd_index : '0);
        exp_rd[3] = (uop_in[0].uop_class == rvv_backend_pkg::VVV) ? uop_in[0].vd_index : t1[4:0];
        src0 = read_set(uop_in[0]);
        src1 = read_set(uop_in[1]);
        for (int i = 0; i < 2; i++) begin
            unit_up[i] = (uop_in[i].uop_exe_unit == rvv_backend_pkg::MAC) ? mac_ready : alu_ready;
        end
        vr_hit = (uop_in[0].uop_class == rvv_backend_pkg::VVV && uop_in[1].uop_class inside
                  {rvv_backend_pkg::VVV, rvv_backend_pkg::XVV, rvv_backend_pkg::VVX}) ||
                 (uop_in[1].uop_class == rvv_backend_pkg::VVV && uop_in[0].uop_class inside
                  {rvv_backend_pkg::XVV, rvv_backend_pkg::VVX});
        mac_pair = uop_in[0].uop_exe_unit == rvv_backend_pkg::MAC &&
                   uop_in[1].uop_exe_unit == rvv_backend_pkg::MAC;
        exp_accept[0] = uop_in[0].valid && unit_up[0] && (src0 & model_pending) == '0;
        exp_accept[1] = exp_accept[0] && uop_in[1].valid && unit_up[1] && !vr_hit &&
                        !mac_pair && (src1 & model_pending) == '0 && !src1[uop_in[0].vd_index];
    end

    // accepted uops land in their unit's slots in program order
    always_comb begin
        issue_next = '0;
        for (int i = 0; i < 2; i++) begin
            if (exp_accept[i] && uop_in[i].uop_exe_unit == rvv_backend_pkg::MAC) begin
                issue_next[2] = uop_in[i];
            end else if (exp_accept[i]) begin
                issue_next[issue_next[0].valid ? 1 : 0] = uop_in[i];
            end
        end
        for (int i = 0; i < 2; i++) begin
            dut_issue[i]     = alu_issue[i].valid ? alu_issue[i] : '0;
            dut_issue[i + 2] = mac_issue[i].valid ? mac_issue[i] : '0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            model_pending <= '0;
            exp_issue     <= '0;
        end else begin
            model_pending <= (model_pending & ~((32'd1 << wb_index) & {32{wb_valid}})) |
                             ((32'd1 << uop_in[0].vd_index) & {32{exp_accept[0]}}) |
                             ((32'd1 << uop_in[1].vd_index) & {32{exp_accept[1]}});
            exp_issue     <= issue_next;
        end
    end

    // queue head drives the DUT and is popped by the accept strobe
    always @(posedge clk) begin
        if (!reset && uop_accept[1]) begin
            void'(uop_q.pop_front());
            void'(uop_q.pop_front());
        end else if (!reset && uop_accept[0]) begin
            void'(uop_q.pop_front());
        end
        uop_in <= '0;
        if (uop_q.size() > 0) begin
            uop_in[0] <= uop_q[0];
        end
        if (uop_q.size() > 1) begin
            uop_in[1] <= uop_q[1];
        end
    end

    assert property (@(posedge clk) disable iff (reset) uop_accept != 2'b10)
        else begin
            errors++;
            $display("uop1 was accepted while uop0 was held");
        end
    assert property (@(posedge clk) disable iff (reset) uop_accept == exp_accept)
        else report_value("uop_accept", $sampled(exp_accept), $sampled(uop_accept));
    assert property (@(posedge clk) disable iff (reset) rd_index == exp_rd)
        else report_value("rd_index", $sampled(exp_rd), $sampled(rd_index));
    assert property (@(posedge clk) disable iff (reset) dut_issue == exp_issue)
        else report_value("issue slots", $sampled(exp_issue), $sampled(dut_issue));

    task automatic report_value(input string test, input logic [127:0] expected,
                                input logic [127:0] actual);
        errors++;
        $display("Error %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    endtask

    task automatic finish_run();
        $display("closing: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic push_uop(input rvv_backend_pkg::uop_class_e cls,
                            input rvv_backend_pkg::exe_unit_e unit,
                            input int vd, input int vs2, input int vs1);
        rvv_backend_pkg::strct_uop_t u;
        u.valid        = 1'b1;
        u.tag          = next_tag;
        u.uop_class    = cls;
        u.uop_exe_unit = unit;
        u.vd_index     = rvv_backend_pkg::reg_index_t'(vd);
        u.vs2_index    = rvv_backend_pkg::reg_index_t'(vs2);
        u.vs1_index    = rvv_backend_pkg::reg_index_t'(vs1);
        next_tag++;
        uop_q.push_back(u);
    endtask

    task automatic push_random();
        logic [31:0] r;
        rng_state = xorshift32(rng_state);
        r = rng_state;
        push_uop(rvv_backend_pkg::uop_class_e'(r[2:0] % 3'd7),
                 rvv_backend_pkg::exe_unit_e'(r[3]), r[8:4], r[13:9], r[18:14]);
    endtask

    // drain the queue and optionally write back every pending register
    task automatic wait_idle(input logic clear_pending, input string what);
        int cycles;
        cycles = 0;
        while (uop_q.size() != 0 || (clear_pending && model_pending != '0)) begin
            @(posedge clk);
            wb_valid <= clear_pending && model_pending != '0;
            wb_index <= lowest_set(model_pending);
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                give_up(what);
            end
        end
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic wait_head(input logic [7:0] tag);
        int cycles;
        cycles = 0;
        while (!(uop_in[0].valid && uop_in[0].tag == tag)) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                give_up("a uop at the queue head");
            end
        end
    endtask

    initial begin
        int cycles;
        logic [7:0] tag_b;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                give_up("reset release");
            end
        end

        // both units busy from reset on so the pair must wait
        push_uop(rvv_backend_pkg::XVX, rvv_backend_pkg::ALU, 1, 2, 0);
        push_uop(rvv_backend_pkg::XXV, rvv_backend_pkg::MAC, 3, 0, 4);
        repeat (6) @(posedge clk);
        alu_ready <= 1'b1;
        mac_ready <= 1'b1;
        wait_idle(1'b1, "back-pressure pair");

        // read-port limit, then two MAC uops, then a legal mixed pair
        @(negedge clk);
        push_uop(rvv_backend_pkg::VVV, rvv_backend_pkg::ALU, 5, 6, 7);
        push_uop(rvv_backend_pkg::VVV, rvv_backend_pkg::ALU, 8, 9, 10);
        wait_idle(1'b1, "vr_limit pair");
        @(negedge clk);
        push_uop(rvv_backend_pkg::XVV, rvv_backend_pkg::MAC, 11, 12, 13);
        push_uop(rvv_backend_pkg::XVX, rvv_backend_pkg::MAC, 14, 15, 0);
        wait_idle(1'b1, "MAC pair");
        @(negedge clk);
        push_uop(rvv_backend_pkg::VXX, rvv_backend_pkg::ALU, 16, 0, 0);
        push_uop(rvv_backend_pkg::XVV, rvv_backend_pkg::MAC, 17, 18, 19);
        wait_idle(1'b1, "legal pair");

        // uop1 reads uop0's vd
        @(negedge clk);
        push_uop(rvv_backend_pkg::XXV, rvv_backend_pkg::ALU, 20, 0, 21);
        push_uop(rvv_backend_pkg::XVX, rvv_backend_pkg::ALU, 22, 20, 0);
        wait_idle(1'b1, "dependent pair");

        // v7 stays pending and its consumer waits for the writeback
        @(negedge clk);
        push_uop(rvv_backend_pkg::XXX, rvv_backend_pkg::MAC, 7, 0, 0);
        wait_idle(1'b0, "producer of v7");
        @(negedge clk);
        push_uop(rvv_backend_pkg::XXV, rvv_backend_pkg::ALU, 23, 0, 7);
        repeat (4) @(posedge clk);
        wb_valid <= 1'b1;
        wb_index <= 5'd7;
        @(posedge clk);
        wb_valid <= 1'b0;
        wait_idle(1'b1, "consumer of v7");

        // writeback of v5 on the same edge as a new producer of v5
        @(negedge clk);
        push_uop(rvv_backend_pkg::XXX, rvv_backend_pkg::ALU, 5, 0, 0);
        wait_idle(1'b0, "first producer of v5");
        alu_ready <= 1'b0;
        @(negedge clk);
        tag_b = next_tag;
        push_uop(rvv_backend_pkg::XXX, rvv_backend_pkg::ALU, 5, 0, 0);
        push_uop(rvv_backend_pkg::XVX, rvv_backend_pkg::ALU, 24, 5, 0);
        wait_head(tag_b);
        @(posedge clk);
        alu_ready <= 1'b1;
        wb_valid  <= 1'b1;
        wb_index  <= 5'd5;
        @(posedge clk);
        wb_valid <= 1'b0;
        repeat (3) @(posedge clk);
        wait_idle(1'b1, "reader of v5");

        for (int n = 0; n < 40; n++) begin
            @(negedge clk);
            push_random();
            push_random();
            wait_idle(1'b1, "random pair");
        end
        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

// File: verilog/rvv_backend_dispatch.sv
// Top of the vector dispatch stage. Takes up to two uops from the queue
// head, drives the VRF read indexes and issues to the ALU and MAC
// reservation stations one cycle after acceptance.

module rvv_backend_dispatch (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] uop_in,
    input  logic                                                          alu_ready,
    input  logic                                                          mac_ready,
    input  logic                                                          wb_valid,
    input  rvv_backend_pkg::reg_index_t                                   wb_index,
    output logic [rvv_backend_pkg::num_dp_uop-1:0]                        uop_accept,
    output rvv_backend_pkg::reg_index_t [rvv_backend_pkg::num_dp_vrf-1:0] rd_index,
    output rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] alu_issue,
    output rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] mac_issue
);

    rvv_backend_pkg::arch_hazard_t                                 arch_hazard;
    rvv_backend_pkg::vreg_mask_t                                   pending;
    rvv_backend_pkg::reg_index_t [rvv_backend_pkg::num_dp_uop-1:0] vd_index;

    // destinations go to the scoreboard
    for (genvar i = 0; i < rvv_backend_pkg::num_dp_uop; i++) begin : gen_vd
        assign vd_index[i] = uop_in[i].vd_index;
    end

    rvv_backend_dispatch_structure_hazard i_structure_hazard (
        .strct_uop   (uop_in),
        .rd_index    (rd_index),
        .arch_hazard (arch_hazard)
    );

    rvv_backend_dispatch_scoreboard i_scoreboard (
        .clk       (clk),
        .reset     (reset),
        .set_valid (uop_accept),
        .set_index (vd_index),
        .wb_valid  (wb_valid),
        .wb_index  (wb_index),
        .pending   (pending)
    );

    rvv_backend_dispatch_ctrl i_ctrl (
        .clk         (clk),
        .reset       (reset),
        .strct_uop   (uop_in),
        .arch_hazard (arch_hazard),
        .pending     (pending),
        .alu_ready   (alu_ready),
        .mac_ready   (mac_ready),
        .uop_accept  (uop_accept),
        .alu_issue   (alu_issue),
        .mac_issue   (mac_issue)
    );

endmodule

// File: verilog/rvv_backend_dispatch_ctrl.sv
// Dispatch decision for the uop pair at the queue head.
// Checks RAW hazards against the scoreboard and inside the pair, applies
// the structure limits and unit ready levels, then registers the
// dispatched uops into the ALU and MAC issue slots.

module rvv_backend_dispatch_ctrl (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] strct_uop,
    input  rvv_backend_pkg::arch_hazard_t                                 arch_hazard,
    input  rvv_backend_pkg::vreg_mask_t                                   pending,
    input  logic                                                          alu_ready,
    input  logic                                                          mac_ready,
    output logic [rvv_backend_pkg::num_dp_uop-1:0]                        uop_accept,
    output rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] alu_issue,
    output rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] mac_issue
);

    // registers a uop reads, decoded from its class
    function automatic rvv_backend_pkg::vreg_mask_t src_mask(
        input rvv_backend_pkg::strct_uop_t u
    );
        rvv_backend_pkg::vreg_mask_t m;
        logic read_vd;
        logic read_vs2;
        logic read_vs1;
        read_vd  = u.uop_class inside {rvv_backend_pkg::VVV, rvv_backend_pkg::VVX,
                                       rvv_backend_pkg::VXX};
        read_vs2 = u.uop_class inside {rvv_backend_pkg::VVV, rvv_backend_pkg::VVX,
                                       rvv_backend_pkg::XVV, rvv_backend_pkg::XVX};
        read_vs1 = u.uop_class inside {rvv_backend_pkg::VVV, rvv_backend_pkg::XVV,
                                       rvv_backend_pkg::XXV};
        m = '0;
        if (read_vd) begin
            m[u.vd_index] = 1'b1;
        end
        if (read_vs2) begin
            m[u.vs2_index] = 1'b1;
        end
        if (read_vs1) begin
            m[u.vs1_index] = 1'b1;
        end
        return m;
    endfunction

    rvv_backend_pkg::vreg_mask_t [rvv_backend_pkg::num_dp_uop-1:0] src;
    logic [rvv_backend_pkg::num_dp_uop-1:0]                        unit_ready;
    logic [rvv_backend_pkg::num_dp_uop-1:0]                        raw_hazard;
    logic                                                          pair_dep;
    rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] alu_next;
    rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] mac_next;

    always_comb begin
        for (int i = 0; i < rvv_backend_pkg::num_dp_uop; i++) begin
            src[i]        = src_mask(strct_uop[i]);
            raw_hazard[i] = |(src[i] & pending);
            unit_ready[i] = (strct_uop[i].uop_exe_unit == rvv_backend_pkg::MAC) ?
                            mac_ready : alu_ready;
        end
    end

    // uop1 reading uop0's result has to wait a cycle
    assign pair_dep = src[1][strct_uop[0].vd_index];

    // uop1 never goes without uop0
    assign uop_accept[0] = strct_uop[0].valid && unit_ready[0] && !raw_hazard[0];
    assign uop_accept[1] = uop_accept[0] && strct_uop[1].valid &&
                           !arch_hazard.vr_limit && !arch_hazard.pu_limit &&
                           unit_ready[1] && !raw_hazard[1] && !pair_dep;

    // steer accepted uops to their unit with the older uop first
    always_comb begin
        alu_next = '0;
        mac_next = '0;
        for (int i = 0; i < rvv_backend_pkg::num_dp_uop; i++) begin
            if (uop_accept[i]) begin
                if (strct_uop[i].uop_exe_unit == rvv_backend_pkg::MAC) begin
                    mac_next[0] = strct_uop[i];
                end else if (alu_next[0].valid) begin
                    alu_next[1] = strct_uop[i];
                end else begin
                    alu_next[0] = strct_uop[i];
                end
            end
        end
    end

    // issue slots toward the reservation stations
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rvv_backend_pkg::num_dp_uop; i++) begin
                alu_issue[i].valid <= 1'b0;
                mac_issue[i].valid <= 1'b0;
            end
        end else begin
            alu_issue <= alu_next;
            mac_issue <= mac_next;
        end
    end

endmodule

// File: verilog/rvv_backend_dispatch_scoreboard.sv
// Pending-write scoreboard, one bit per vector register.
// A bit is set when a uop writing that register dispatches and
// cleared by the writeback pulse; a set on the same edge wins.

module rvv_backend_dispatch_scoreboard (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  logic [rvv_backend_pkg::num_dp_uop-1:0]                        set_valid,
    input  rvv_backend_pkg::reg_index_t [rvv_backend_pkg::num_dp_uop-1:0] set_index,
    input  logic                                                          wb_valid,
    input  rvv_backend_pkg::reg_index_t                                   wb_index,
    output rvv_backend_pkg::vreg_mask_t                                   pending
);

    rvv_backend_pkg::vreg_mask_t set_mask;
    rvv_backend_pkg::vreg_mask_t clr_mask;

    // destinations of the uops accepted this cycle
    always_comb begin
        set_mask = '0;
        for (int i = 0; i < rvv_backend_pkg::num_dp_uop; i++) begin
            if (set_valid[i]) begin
                set_mask[set_index[i]] = 1'b1;
            end
        end
    end

    // register retired by writeback
    always_comb begin
        clr_mask = '0;
        if (wb_valid) begin
            clr_mask[wb_index] = 1'b1;
        end
    end

    // set is or'ed in after the clear so it takes priority
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

endmodule

// File: verilog/rvv_backend_dispatch_structure_hazard.sv
// Maps the operands of the uop pair onto the four VRF read ports and
// flags the structure limits (read ports, single MAC) of the pair.
// Purely combinational, fed straight from the head of the uop queue.

module rvv_backend_dispatch_structure_hazard (
    input  rvv_backend_pkg::strct_uop_t [rvv_backend_pkg::num_dp_uop-1:0] strct_uop,
    output rvv_backend_pkg::reg_index_t [rvv_backend_pkg::num_dp_vrf-1:0] rd_index,
    output rvv_backend_pkg::arch_hazard_t                                 arch_hazard
);

    // a uop's first read port takes vs2 if read and otherwise vd or vs1
    function automatic rvv_backend_pkg::reg_index_t first_port(
        input rvv_backend_pkg::strct_uop_t u
    );
        case (u.uop_class)
            rvv_backend_pkg::VVV,
            rvv_backend_pkg::VVX,
            rvv_backend_pkg::XVV,
            rvv_backend_pkg::XVX: begin
                first_port = u.vs2_index;
            end
            rvv_backend_pkg::VXX: begin
                first_port = u.vd_index;
            end
            rvv_backend_pkg::XXV: begin
                first_port = u.vs1_index;
            end
            default: begin
                first_port = '0;
            end
        endcase
    endfunction

    // second read port of a uop, or the given fallback when it has none
    function automatic rvv_backend_pkg::reg_index_t second_port(
        input rvv_backend_pkg::strct_uop_t u,
        input rvv_backend_pkg::reg_index_t fallback
    );
        case (u.uop_class)
            rvv_backend_pkg::VVV,
            rvv_backend_pkg::XVV: begin
                second_port = u.vs1_index;
            end
            rvv_backend_pkg::VVX: begin
                second_port = u.vd_index;
            end
            default: begin
                second_port = fallback;
            end
        endcase
    endfunction

    logic uop0_vvv;
    logic uop1_vvv;

    assign uop0_vvv = (strct_uop[0].uop_class == rvv_backend_pkg::VVV);
    assign uop1_vvv = (strct_uop[1].uop_class == rvv_backend_pkg::VVV);

    // rd0/rd2 serve the first operand of each uop
    // rd1 and rd3 are shared and a VVV uop borrows the other's spare port for vd
    always_comb begin
        rd_index[0] = first_port(strct_uop[0]);
        rd_index[2] = first_port(strct_uop[1]);

        if (uop1_vvv) begin
            rd_index[1] = second_port(strct_uop[0], strct_uop[1].vd_index);
        end else begin
            rd_index[1] = second_port(strct_uop[0], '0);
        end

        if (uop0_vvv) begin
            rd_index[3] = strct_uop[0].vd_index;
        end else begin
            rd_index[3] = second_port(strct_uop[1], '0);
        end
    end

    // pairs needing five or six reads do not fit in four ports
    // and only one MAC uop goes per cycle
    always_comb begin
        arch_hazard.pu_limit = (strct_uop[0].uop_exe_unit == rvv_backend_pkg::MAC) &&
                               (strct_uop[1].uop_exe_unit == rvv_backend_pkg::MAC);
        case ({strct_uop[0].uop_class, strct_uop[1].uop_class})
            {rvv_backend_pkg::VVV, rvv_backend_pkg::VVV},
            {rvv_backend_pkg::VVV, rvv_backend_pkg::XVV},
            {rvv_backend_pkg::VVV, rvv_backend_pkg::VVX},
            {rvv_backend_pkg::XVV, rvv_backend_pkg::VVV},
            {rvv_backend_pkg::VVX, rvv_backend_pkg::VVV}: begin
                arch_hazard.vr_limit = 1'b1;
            end
            default: begin
                arch_hazard.vr_limit = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/rvv_backend_pkg.sv
// Shared widths, types and structs for the vector dispatch stage.
// Every dispatch module refers to these by scoped name.

package rvv_backend_pkg;

    // issue width fixed by the two-uop hazard table
    localparam int num_dp_uop = 2;

    // VRF read ports with two per issued uop
    localparam int num_dp_vrf = 4;

    // architectural vector registers
    localparam int num_vreg = 32;

    // program-order tag width
    localparam int uop_tag_width = 8;

    // vector register index
    typedef logic [$clog2(num_vreg)-1:0] reg_index_t;

    // program-order tag carried by each uop
    typedef logic [uop_tag_width-1:0] uop_tag_t;

    // one bit per vector register
    typedef logic [num_vreg-1:0] vreg_mask_t;

    // operand pattern in vd, vs2, vs1 order
    // V is a vector register read, X is not read
    // vd is a source only for VVV, VVX and VXX
    typedef enum logic [2:0] {
        VVV,
        VVX,
        VXX,
        XVV,
        XVX,
        XXV,
        XXX
    } uop_class_e;

    // target execution unit
    typedef enum logic {
        ALU,
        MAC
    } exe_unit_e;

    // uop as it leaves the queue and enters a reservation station
    typedef struct packed {
        logic       valid;
        uop_tag_t   tag;
        uop_class_e uop_class;
        exe_unit_e  uop_exe_unit;
        reg_index_t vd_index;
        reg_index_t vs2_index;
        reg_index_t vs1_index;
    } strct_uop_t;

    // structure limits of the current pair
    typedef struct packed {
        // pair needs more than four VRF reads
        logic vr_limit;
        // both uops need the single MAC
        logic pu_limit;
    } arch_hazard_t;

endpackage
